/* src/xbar_cfg_pkg.sv */
`default_nettype none

// Address map and sizing of the 2x2 APB crossbar
package xbar_cfg_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 2;

    // Slave n owns [BASE_ADDR + n*64K, BASE_ADDR + (n+1)*64K)
    localparam logic [ADDR_W-1:0] BASE_ADDR = 32'h1000_0000;
    localparam int                WIN_LSB   = 16;
    localparam int                SEL_W     = 1;

    // Anything at or past BASE_ADDR + MAP_SIZE is unmapped
    localparam logic [ADDR_W-1:0] MAP_SIZE  = 32'h0002_0000;

endpackage

`default_nettype wire

/* src/apb_pkg.sv */
`default_nettype none

// Phase encodings of the APB port state machines
package apb_pkg;

    // Master-side port
    typedef enum logic [2:0] {
        TGT_IDLE, TGT_CMD, TGT_WAIT, TGT_DONE, TGT_ERR
    } tgt_state_e;

    // Slave-side port
    typedef enum logic [1:0] {
        INI_IDLE, INI_SETUP, INI_ACCESS, INI_RESP
    } ini_state_e;

endpackage

`default_nettype wire

/* src/apb_target_port.sv */
`timescale 1ns/100ps
`default_nettype none

// Master-side APB port: decodes the address, issues one command and
// completes the APB transfer once the response is back
module apb_target_port (
    input  wire logic                              pclk,
    input  wire logic                              arst_n,
    input  wire logic                              psel,
    input  wire logic                              penable,
    input  wire logic                              pwrite,
    input  wire logic [xbar_cfg_pkg::ADDR_W-1:0]   paddr,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   pwdata,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output logic                                   cmd_valid,
    input  wire logic                              cmd_ready,
    output logic      [xbar_cfg_pkg::SEL_W-1:0]    cmd_slave,
    output logic                                   cmd_write,
    output logic      [xbar_cfg_pkg::ADDR_W-1:0]   cmd_addr,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   cmd_wdata,
    output logic      [xbar_cfg_pkg::SEL_W-1:0]    rsp_slave,
    input  wire logic                              rsp_valid,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   rsp_rdata,
    input  wire logic                              rsp_err
);

    apb_pkg::tgt_state_e                state_q;
    logic                               access;
    logic                               in_range;
    logic [xbar_cfg_pkg::DATA_W-1:0]    rdata_q;
    logic                               err_q;

    assign access   = psel && penable;
    assign in_range = (paddr >= xbar_cfg_pkg::BASE_ADDR) &&
                      (paddr < xbar_cfg_pkg::BASE_ADDR + xbar_cfg_pkg::MAP_SIZE);

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= apb_pkg::TGT_IDLE;
            rsp_slave <= '0;
        end else begin
            case (state_q)
                apb_pkg::TGT_IDLE: begin
                    if (access) begin
                        state_q <= in_range ? apb_pkg::TGT_CMD : apb_pkg::TGT_ERR;
                    end
                end
                apb_pkg::TGT_CMD: begin
                    if (cmd_ready) begin
                        state_q   <= apb_pkg::TGT_WAIT;
                        // Remember which slave will answer
                        rsp_slave <= cmd_slave;
                    end
                end
                apb_pkg::TGT_WAIT: begin
                    if (rsp_valid) begin
                        state_q <= apb_pkg::TGT_DONE;
                    end
                end
                default: state_q <= apb_pkg::TGT_IDLE;
            endcase
        end
    end

    // Command fields held from capture until the command is taken
    always_ff @(posedge pclk) begin
        if (state_q == apb_pkg::TGT_IDLE && access) begin
            cmd_write <= pwrite;
            cmd_addr  <= paddr;
            cmd_wdata <= pwdata;
            cmd_slave <= paddr[xbar_cfg_pkg::WIN_LSB +: xbar_cfg_pkg::SEL_W];
        end
        if (state_q == apb_pkg::TGT_WAIT && rsp_valid) begin
            rdata_q <= rsp_rdata;
            err_q   <= rsp_err;
        end
    end

    assign cmd_valid = (state_q == apb_pkg::TGT_CMD);
    assign pready    = (state_q == apb_pkg::TGT_DONE) || (state_q == apb_pkg::TGT_ERR);
    // Unmapped accesses end with zero data and an error
    assign prdata    = (state_q == apb_pkg::TGT_DONE) ? rdata_q : '0;
    assign pslverr   = (state_q == apb_pkg::TGT_ERR) ||
                       ((state_q == apb_pkg::TGT_DONE) && err_q);

    a_cmd_hold: assert property (@(posedge pclk) disable iff (!arst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_addr));

    // The external master must still be in its access phase
    a_pready_in_access: assert property (@(posedge pclk) disable iff (!arst_n)
        pready |-> psel && penable);

endmodule

`default_nettype wire

/* src/slave_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

// Round-robin arbiter for one slave, with the grant locked from command
// transfer until that slave's response, plus the command multiplexer
module slave_arbiter (
    input  wire logic                                 pclk,
    input  wire logic                                 arst_n,
    input  wire logic [xbar_cfg_pkg::NUM_MASTERS-1:0] req,
    input  wire logic                                 m0_write,
    input  wire logic [xbar_cfg_pkg::ADDR_W-1:0]      m0_addr,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]      m0_wdata,
    input  wire logic                                 m1_write,
    input  wire logic [xbar_cfg_pkg::ADDR_W-1:0]      m1_addr,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]      m1_wdata,
    output logic      [xbar_cfg_pkg::NUM_MASTERS-1:0] m_ready,
    output logic      [xbar_cfg_pkg::NUM_MASTERS-1:0] grant,
    output logic                                      s_valid,
    output logic                                      s_write,
    output logic      [xbar_cfg_pkg::ADDR_W-1:0]      s_addr,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]      s_wdata,
    input  wire logic                                 s_ready,
    input  wire logic                                 s_done
);

    logic                                  lock_q;
    logic                                  last_q;
    logic [xbar_cfg_pkg::NUM_MASTERS-1:0]  pick;

    // On a tie the master not served last wins
    assign pick[0] = req[0] && (!req[1] || last_q);
    assign pick[1] = req[1] && (!req[0] || !last_q);

    // While locked, last_q names the owner of the slave
    assign grant = lock_q ? (xbar_cfg_pkg::NUM_MASTERS'(1) << last_q) : pick;

    assign s_valid = |(req & grant);
    assign m_ready = grant & {xbar_cfg_pkg::NUM_MASTERS{s_ready}};

    assign s_write = grant[1] ? m1_write : m0_write;
    assign s_addr  = grant[1] ? m1_addr  : m0_addr;
    assign s_wdata = grant[1] ? m1_wdata : m0_wdata;

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            lock_q <= 1'b0;
            // Master 0 takes the first tie
            last_q <= 1'b1;
        end else if (s_valid && s_ready) begin
            lock_q <= 1'b1;
            last_q <= grant[1];
        end else if (s_done) begin
            lock_q <= 1'b0;
        end
    end

    a_grant_onehot: assert property (@(posedge pclk) disable iff (!arst_n)
        $onehot0(grant));

endmodule

`default_nettype wire

/* src/apb_initiator_port.sv */
`timescale 1ns/100ps
`default_nettype none

// Slave-side APB port, turns one command into a setup/access transfer
module apb_initiator_port (
    input  wire logic                              pclk,
    input  wire logic                              arst_n,
    input  wire logic                              cmd_valid,
    output logic                                   cmd_ready,
    input  wire logic                              cmd_write,
    input  wire logic [xbar_cfg_pkg::ADDR_W-1:0]   cmd_addr,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   cmd_wdata,
    output logic                                   rsp_valid,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   rsp_rdata,
    output logic                                   rsp_err,
    output logic                                   psel,
    output logic                                   penable,
    output logic      [xbar_cfg_pkg::ADDR_W-1:0]   paddr,
    output logic                                   pwrite,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   pwdata,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   prdata,
    input  wire logic                              pready,
    input  wire logic                              pslverr
);

    apb_pkg::ini_state_e state_q;

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= apb_pkg::INI_IDLE;
        end else begin
            case (state_q)
                apb_pkg::INI_IDLE: begin
                    if (cmd_valid) begin
                        state_q <= apb_pkg::INI_SETUP;
                    end
                end
                apb_pkg::INI_SETUP:  state_q <= apb_pkg::INI_ACCESS;
                apb_pkg::INI_ACCESS: begin
                    // Slave wait states hold us here
                    if (pready) begin
                        state_q <= apb_pkg::INI_RESP;
                    end
                end
                default: state_q <= apb_pkg::INI_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (cmd_valid && cmd_ready) begin
            paddr  <= cmd_addr;
            pwrite <= cmd_write;
            pwdata <= cmd_wdata;
        end
        if (state_q == apb_pkg::INI_ACCESS && pready) begin
            rsp_rdata <= prdata;
            rsp_err   <= pslverr;
        end
    end

    assign cmd_ready = (state_q == apb_pkg::INI_IDLE);
    assign psel      = (state_q == apb_pkg::INI_SETUP) || (state_q == apb_pkg::INI_ACCESS);
    assign penable   = (state_q == apb_pkg::INI_ACCESS);
    assign rsp_valid = (state_q == apb_pkg::INI_RESP);

    a_paddr_stable: assert property (@(posedge pclk) disable iff (!arst_n)
        psel && $past(psel) |-> $stable(paddr));

endmodule

`default_nettype wire

/* src/apb_xbar_2to2.sv */
`timescale 1ns/100ps
`default_nettype none

// APB crossbar, two masters to two slaves
module apb_xbar_2to2 (
    input  wire logic                              pclk,
    input  wire logic                              arst_n,
    input  wire logic                              m0_psel,
    input  wire logic                              m0_penable,
    input  wire logic [xbar_cfg_pkg::ADDR_W-1:0]   m0_paddr,
    input  wire logic                              m0_pwrite,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   m0_pwdata,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   m0_prdata,
    output logic                                   m0_pready,
    output logic                                   m0_pslverr,
    input  wire logic                              m1_psel,
    input  wire logic                              m1_penable,
    input  wire logic [xbar_cfg_pkg::ADDR_W-1:0]   m1_paddr,
    input  wire logic                              m1_pwrite,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   m1_pwdata,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   m1_prdata,
    output logic                                   m1_pready,
    output logic                                   m1_pslverr,
    output logic                                   s0_psel,
    output logic                                   s0_penable,
    output logic      [xbar_cfg_pkg::ADDR_W-1:0]   s0_paddr,
    output logic                                   s0_pwrite,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   s0_pwdata,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   s0_prdata,
    input  wire logic                              s0_pready,
    input  wire logic                              s0_pslverr,
    output logic                                   s1_psel,
    output logic                                   s1_penable,
    output logic      [xbar_cfg_pkg::ADDR_W-1:0]   s1_paddr,
    output logic                                   s1_pwrite,
    output logic      [xbar_cfg_pkg::DATA_W-1:0]   s1_pwdata,
    input  wire logic [xbar_cfg_pkg::DATA_W-1:0]   s1_prdata,
    input  wire logic                              s1_pready,
    input  wire logic                              s1_pslverr
);

    localparam int NM = xbar_cfg_pkg::NUM_MASTERS;
    localparam int NS = xbar_cfg_pkg::NUM_SLAVES;

    // Master-side APB, packed by master index
    logic [NM-1:0]                            m_psel, m_penable, m_pwrite;
    logic [NM-1:0]                            m_pready, m_pslverr;
    logic [NM-1:0][xbar_cfg_pkg::ADDR_W-1:0]  m_paddr;
    logic [NM-1:0][xbar_cfg_pkg::DATA_W-1:0]  m_pwdata, m_prdata;

    // Slave-side APB, packed by slave index
    logic [NS-1:0]                            s_psel, s_penable, s_pwrite;
    logic [NS-1:0]                            s_pready, s_pslverr;
    logic [NS-1:0][xbar_cfg_pkg::ADDR_W-1:0]  s_paddr;
    logic [NS-1:0][xbar_cfg_pkg::DATA_W-1:0]  s_pwdata, s_prdata;

    // Per-master command and response
    logic [NM-1:0]                            cmd_valid, cmd_ready, cmd_write;
    logic [NM-1:0][xbar_cfg_pkg::SEL_W-1:0]   cmd_slave, rsp_slave;
    logic [NM-1:0][xbar_cfg_pkg::ADDR_W-1:0]  cmd_addr;
    logic [NM-1:0][xbar_cfg_pkg::DATA_W-1:0]  cmd_wdata, rsp_rdata;
    logic [NM-1:0]                            rsp_valid, rsp_err;

    // Per-slave arbitration and initiator side
    logic [NS-1:0][NM-1:0]                    arb_req, arb_grant, arb_ready;
    logic [NS-1:0]                            ini_cmd_valid, ini_cmd_ready, ini_cmd_write;
    logic [NS-1:0][xbar_cfg_pkg::ADDR_W-1:0]  ini_cmd_addr;
    logic [NS-1:0][xbar_cfg_pkg::DATA_W-1:0]  ini_cmd_wdata, ini_rsp_rdata;
    logic [NS-1:0]                            ini_rsp_valid, ini_rsp_err;

    assign m_psel    = {m1_psel, m0_psel};
    assign m_penable = {m1_penable, m0_penable};
    assign m_pwrite  = {m1_pwrite, m0_pwrite};
    assign m_paddr   = {m1_paddr, m0_paddr};
    assign m_pwdata  = {m1_pwdata, m0_pwdata};
    assign {m1_prdata, m0_prdata}   = m_prdata;
    assign {m1_pready, m0_pready}   = m_pready;
    assign {m1_pslverr, m0_pslverr} = m_pslverr;

    assign {s1_psel, s0_psel}       = s_psel;
    assign {s1_penable, s0_penable} = s_penable;
    assign {s1_pwrite, s0_pwrite}   = s_pwrite;
    assign {s1_paddr, s0_paddr}     = s_paddr;
    assign {s1_pwdata, s0_pwdata}   = s_pwdata;
    assign s_prdata  = {s1_prdata, s0_prdata};
    assign s_pready  = {s1_pready, s0_pready};
    assign s_pslverr = {s1_pslverr, s0_pslverr};

    for (genvar m = 0; m < NM; m++) begin : g_master
        apb_target_port u_tgt (
            .pclk      (pclk),       .arst_n    (arst_n),
            .psel      (m_psel[m]),  .penable   (m_penable[m]),
            .pwrite    (m_pwrite[m]), .paddr    (m_paddr[m]),
            .pwdata    (m_pwdata[m]), .prdata   (m_prdata[m]),
            .pready    (m_pready[m]), .pslverr  (m_pslverr[m]),
            .cmd_valid (cmd_valid[m]), .cmd_ready (cmd_ready[m]),
            .cmd_slave (cmd_slave[m]), .cmd_write (cmd_write[m]),
            .cmd_addr  (cmd_addr[m]),  .cmd_wdata (cmd_wdata[m]),
            .rsp_slave (rsp_slave[m]), .rsp_valid (rsp_valid[m]),
            .rsp_rdata (rsp_rdata[m]), .rsp_err   (rsp_err[m])
        );

        // Ready from the arbiter of the addressed slave
        assign cmd_ready[m] = arb_ready[cmd_slave[m]][m];

        // Response only while that slave's grant still names this master
        assign rsp_valid[m] = ini_rsp_valid[rsp_slave[m]] && arb_grant[rsp_slave[m]][m];
        assign rsp_rdata[m] = ini_rsp_rdata[rsp_slave[m]];
        assign rsp_err[m]   = ini_rsp_err[rsp_slave[m]];
    end

    for (genvar s = 0; s < NS; s++) begin : g_slave
        always_comb begin
            for (int m = 0; m < NM; m++) begin
                arb_req[s][m] = cmd_valid[m] && (cmd_slave[m] == xbar_cfg_pkg::SEL_W'(s));
            end
        end

        slave_arbiter u_arb (
            .pclk     (pclk),            .arst_n   (arst_n),
            .req      (arb_req[s]),
            .m0_write (cmd_write[0]),    .m0_addr  (cmd_addr[0]),
            .m0_wdata (cmd_wdata[0]),
            .m1_write (cmd_write[1]),    .m1_addr  (cmd_addr[1]),
            .m1_wdata (cmd_wdata[1]),
            .m_ready  (arb_ready[s]),    .grant    (arb_grant[s]),
            .s_valid  (ini_cmd_valid[s]), .s_write (ini_cmd_write[s]),
            .s_addr   (ini_cmd_addr[s]), .s_wdata  (ini_cmd_wdata[s]),
            .s_ready  (ini_cmd_ready[s]), .s_done  (ini_rsp_valid[s])
        );

        apb_initiator_port u_ini (
            .pclk      (pclk),              .arst_n    (arst_n),
            .cmd_valid (ini_cmd_valid[s]),  .cmd_ready (ini_cmd_ready[s]),
            .cmd_write (ini_cmd_write[s]),  .cmd_addr  (ini_cmd_addr[s]),
            .cmd_wdata (ini_cmd_wdata[s]),
            .rsp_valid (ini_rsp_valid[s]),  .rsp_rdata (ini_rsp_rdata[s]),
            .rsp_err   (ini_rsp_err[s]),
            .psel      (s_psel[s]),         .penable   (s_penable[s]),
            .paddr     (s_paddr[s]),        .pwrite    (s_pwrite[s]),
            .pwdata    (s_pwdata[s]),       .prdata    (s_prdata[s]),
            .pready    (s_pready[s]),       .pslverr   (s_pslverr[s])
        );
    end

endmodule

`default_nettype wire

/* verif/apb_mem_slave.sv */
`timescale 1ns/100ps
`default_nettype none

// APB memory model with fixed wait states and one error offset per window
module apb_mem_slave #(
    parameter int WAIT_STATES = 0
) (
    input  wire logic        pclk,
    input  wire logic        arst_n,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic [31:0] paddr,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr
);

    localparam logic [15:0] ERR_OFFSET = 16'hFFFC;

    logic [31:0] mem [0:16383];
    logic        err_addr;
    int          wait_cnt;

    // Setup-phase address of every PSEL session, in arrival order
    logic [31:0] log_addr [0:63];
    int          log_cnt;

    assign err_addr = (paddr[15:0] == ERR_OFFSET);
    assign pready   = psel && penable && (wait_cnt == WAIT_STATES);
    assign pslverr  = pready && err_addr;
    assign prdata   = err_addr ? '0 : mem[paddr[15:2]];

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= 0;
            log_cnt  <= 0;
        end else begin
            if (psel && penable && !pready) begin
                wait_cnt <= wait_cnt + 1;
            end else begin
                wait_cnt <= 0;
            end
            if (psel && !penable) begin
                log_addr[log_cnt[5:0]] <= paddr;
                log_cnt                <= log_cnt + 1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (pready && pwrite && !err_addr) begin
            mem[paddr[15:2]] <= pwdata;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_apb_xbar.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_apb_xbar;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] SEED         = 32'd32;
    localparam logic [31:0] S0_BASE      = xbar_cfg_pkg::BASE_ADDR;
    localparam logic [31:0] S1_BASE      = xbar_cfg_pkg::BASE_ADDR +
                                           (32'd1 << xbar_cfg_pkg::WIN_LSB);
    localparam logic [31:0] ERR_OFFSET   = 32'h0000_FFFC;
    // Random offsets stay in the lower half of a window, clear of ERR_OFFSET
    localparam logic [31:0] OFFSET_MASK  = 32'h0000_7FFC;
    // About 20 transfers of at most 24 cycles each, with a fourfold margin
    localparam int          NUM_XFERS    = 20;
    localparam int          XFER_CYCLES  = 24;
    localparam int          MAX_CYCLES   = 4 * (NUM_XFERS * XFER_CYCLES + RESET_CYCLES);

    logic        pclk;
    logic        arst_n;
    logic        m0_psel, m0_penable, m0_pwrite, m0_pready, m0_pslverr;
    logic [31:0] m0_paddr, m0_pwdata, m0_prdata;
    logic        m1_psel, m1_penable, m1_pwrite, m1_pready, m1_pslverr;
    logic [31:0] m1_paddr, m1_pwdata, m1_prdata;
    logic        s0_psel, s0_penable, s0_pwrite, s0_pready, s0_pslverr;
    logic [31:0] s0_paddr, s0_pwdata, s0_prdata;
    logic        s1_psel, s1_penable, s1_pwrite, s1_pready, s1_pslverr;
    logic [31:0] s1_paddr, s1_pwdata, s1_prdata;

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;

    apb_xbar_2to2 dut0 (.*);

    apb_mem_slave #(.WAIT_STATES(0)) slv0 (
        .pclk(pclk), .arst_n(arst_n), .psel(s0_psel), .penable(s0_penable),
        .paddr(s0_paddr), .pwrite(s0_pwrite), .pwdata(s0_pwdata),
        .prdata(s0_prdata), .pready(s0_pready), .pslverr(s0_pslverr)
    );

    apb_mem_slave #(.WAIT_STATES(2)) slv1 (
        .pclk(pclk), .arst_n(arst_n), .psel(s1_psel), .penable(s1_penable),
        .paddr(s1_paddr), .pwrite(s1_pwrite), .pwdata(s1_pwdata),
        .prdata(s1_prdata), .pready(s1_pready), .pslverr(s1_pslverr)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_PERIOD / 2) pclk = ~pclk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge pclk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, a transfer never completed", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic drive_master(input int m, input logic sel, input logic en,
                                input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata);
        if (m == 0) begin
            m0_psel    = sel;
            m0_penable = en;
            m0_pwrite  = wr;
            m0_paddr   = addr;
            m0_pwdata  = wdata;
        end else begin
            m1_psel    = sel;
            m1_penable = en;
            m1_pwrite  = wr;
            m1_paddr   = addr;
            m1_pwdata  = wdata;
        end
    endtask

    // One APB transfer, outputs sampled at the falling edge before completion
    task automatic apb_xfer(input int m, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        logic done;
        done = 1'b0;
        @(negedge pclk);
        drive_master(m, 1'b1, 1'b0, wr, addr, wdata);
        @(negedge pclk);
        drive_master(m, 1'b1, 1'b1, wr, addr, wdata);
        while (!done) begin
            @(negedge pclk);
            done  = (m == 0) ? m0_pready : m1_pready;
            rdata = (m == 0) ? m0_prdata : m1_prdata;
            err   = (m == 0) ? m0_pslverr : m1_pslverr;
        end
        @(negedge pclk);
        drive_master(m, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic do_write(input int m, input logic [31:0] addr,
                            input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(m, 1'b1, addr, data, rdata, err);
        check_value($sformatf("m%0d_pslverr", m), {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic do_read(input int m, input logic [31:0] addr,
                           input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(m, 1'b0, addr, '0, rdata, err);
        check_value($sformatf("m%0d_pslverr", m), {31'b0, err}, {31'b0, exp_err});
        check_value($sformatf("m%0d_prdata", m), rdata, exp_data);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-32s ok", name);
        end else begin
            tests_failed++;
            $display("test %-32s %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_m0_both_slaves();
        logic [31:0] a0, a1, d0, d1;
        int          errs;
        errs = errors;
        a0 = S0_BASE + (lcg_next() & OFFSET_MASK);
        a1 = S1_BASE + (lcg_next() & OFFSET_MASK);
        d0 = lcg_next();
        d1 = lcg_next();
        do_write(0, a0, d0, 1'b0);
        do_write(0, a1, d1, 1'b0);
        do_read(0, a0, d0, 1'b0);
        do_read(0, a1, d1, 1'b0);
        end_test("master 0 to both slaves", errs);
    endtask

    task automatic test_m1_wait_states();
        logic [31:0] a, d;
        int          errs;
        errs = errors;
        a = S1_BASE + (lcg_next() & OFFSET_MASK);
        d = lcg_next();
        do_write(1, a, d, 1'b0);
        do_read(1, a, d, 1'b0);
        end_test("master 1 with wait states", errs);
    endtask

    task automatic test_unmapped();
        int errs;
        int n0, n1;
        errs = errors;
        n0 = slv0.log_cnt;
        n1 = slv1.log_cnt;
        do_read(0, xbar_cfg_pkg::BASE_ADDR - 32'd4, '0, 1'b1);
        do_read(1, xbar_cfg_pkg::BASE_ADDR + xbar_cfg_pkg::MAP_SIZE, '0, 1'b1);
        // No slave may have seen a PSEL session
        check_value("s0_psel_sessions", slv0.log_cnt, n0);
        check_value("s1_psel_sessions", slv1.log_cnt, n1);
        end_test("unmapped addresses", errs);
    endtask

    task automatic test_slave_error();
        int errs;
        errs = errors;
        do_read(1, S0_BASE + ERR_OFFSET, '0, 1'b1);
        do_read(0, S1_BASE + ERR_OFFSET, '0, 1'b1);
        end_test("slave error response", errs);
    endtask

    task automatic test_parallel();
        logic [31:0] a0, a1, d0, d1;
        int          errs;
        errs = errors;
        a0 = S1_BASE + (lcg_next() & OFFSET_MASK);
        a1 = S0_BASE + (lcg_next() & OFFSET_MASK);
        d0 = lcg_next();
        d1 = lcg_next();
        fork
            do_write(0, a0, d0, 1'b0);
            do_write(1, a1, d1, 1'b0);
        join
        fork
            do_read(0, a0, d0, 1'b0);
            do_read(1, a1, d1, 1'b0);
        join
        end_test("parallel to different slaves", errs);
    endtask

    task automatic test_tie_order();
        logic [31:0] a0, a1, d0, d1;
        int          base_idx;
        int          errs;
        errs = errors;
        a0 = S0_BASE + (lcg_next() & OFFSET_MASK);
        a1 = a0 ^ 32'h0000_4000;
        d0 = lcg_next();
        d1 = lcg_next();
        // Slave 0 was last granted to master 1, so master 0 takes this tie
        base_idx = slv0.log_cnt;
        fork
            do_write(0, a0, d0, 1'b0);
            do_write(1, a1, d1, 1'b0);
        join
        check_value("s0_paddr first", slv0.log_addr[base_idx[5:0]], a0);
        check_value("s0_paddr second", slv0.log_addr[6'(base_idx + 1)], a1);
        // A lone master 0 access leaves master 1 ahead for the next tie
        do_read(0, a1, d1, 1'b0);
        base_idx = slv0.log_cnt;
        fork
            do_read(0, a0, d0, 1'b0);
            do_read(1, a1, d1, 1'b0);
        join
        check_value("s0_paddr first", slv0.log_addr[base_idx[5:0]], a1);
        check_value("s0_paddr second", slv0.log_addr[6'(base_idx + 1)], a0);
        end_test("round-robin ties on slave 0", errs);
    endtask

    initial begin
        arst_n       = 1'b0;
        lcg_state    = SEED;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        drive_master(0, 1'b0, 1'b0, 1'b0, '0, '0);
        drive_master(1, 1'b0, 1'b0, 1'b0, '0, '0);
        repeat (RESET_CYCLES) @(posedge pclk);
        @(negedge pclk);
        arst_n = 1'b1;

        test_m0_both_slaves();
        test_m1_wait_states();
        test_unmapped();
        test_slave_error();
        test_parallel();
        test_tie_order();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/xbar_cfg_pkg.sv
src/apb_pkg.sv
src/apb_target_port.sv
src/slave_arbiter.sv
src/apb_initiator_port.sv
src/apb_xbar_2to2.sv
verif/apb_mem_slave.sv
verif/tb_apb_xbar.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_apb_xbar
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
